// File: common/clkgen_macros.svh
`ifndef CLKGEN_MACROS_SVH
`define CLKGEN_MACROS_SVH

// channel count and divider sizing
`define CLKGEN_NUM_CH      7
`define CLKGEN_CNT_W       8
`define CLKGEN_DIVCFG_W    3   // log2 of ratio, minus one

// lock settling
`define CLKGEN_LOCK_CYCLES 16
`define CLKGEN_LOCK_W      5   // wide enough to hold the settle count

// register map
`define CLKGEN_ADDR_W      7
`define CLKGEN_DATA_W      16
`define CLKGEN_ADDR_STATUS 7'd8   // bit 0 reads back LOCKED

`endif

// File: common/clkgen_pkg.sv
`default_nettype none

`include "clkgen_macros.svh"

package clkgen_pkg;

  // ####################################################################
  // channel setting
  // ####################################################################

  // period is 2**(divcfg+1) CLKIN1 cycles and phase offsets the counter
  typedef struct packed {
    logic [`CLKGEN_CNT_W-1:0]    phase;
    logic [`CLKGEN_DIVCFG_W-1:0] divcfg;
  } div_cfg_t;

  // ####################################################################
  // register port request
  // ####################################################################

  typedef struct packed {
    logic                      en;   // DEN
    logic                      we;   // DWE
    logic [`CLKGEN_ADDR_W-1:0] addr; // DADDR
    logic [`CLKGEN_DATA_W-1:0] data; // DI
  } drp_req_t;

  // lock monitor FSM
  typedef enum logic {
    LOCK_SETTLE = 1'b0,
    LOCK_DONE   = 1'b1
  } lock_state_e;

endpackage

`default_nettype wire

// File: clock_divider/clock_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_macros.svh"

// power-of-two divider for one channel
// the phase offset is added to the edge counter, so a nonzero phase
// shifts the square wave by that many CLKIN1 cycles
module clock_divider (
  input  wire logic                 CLKIN1,
  input  wire logic                 reset,
  input  wire logic                 restart,
  input  wire clkgen_pkg::div_cfg_t cfg,
  output logic                      div_out
);

  logic [`CLKGEN_CNT_W-1:0] cnt;      // free running edge count
  logic [`CLKGEN_CNT_W-1:0] phased;   // count shifted by phase

  // ####################################################################
  // edge counter
  // ####################################################################

  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      cnt <= '0;
    end
    else if (restart)
    begin
      cnt <= '0;   // all channels start together
    end
    else
    begin
      cnt <= cnt + 1'b1;   // wraps
    end
  end

  // ####################################################################
  // output select
  // ####################################################################

  // bit n of the count toggles every 2**n edges,
  // so bit divcfg gives a period of 2**(divcfg+1)
  assign phased  = cnt + cfg.phase;
  assign div_out = phased[cfg.divcfg];

  // restart realigns the counter on the next edge
  cnt_cleared: assert property (
    @(posedge CLKIN1) disable iff (reset)
    restart |=> (cnt == '0)
  ) else $error("divider count not cleared after restart");

endmodule

`default_nettype wire

// File: hdl/clkgen_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_macros.svh"

module clkgen_cfg_regs (
  input  wire logic                      CLKIN1,
  input  wire logic                      reset,
  input  wire clkgen_pkg::drp_req_t      req,
  input  wire logic                      locked,
  output clkgen_pkg::div_cfg_t           ch_cfg [`CLKGEN_NUM_CH],
  output logic                           restart,
  output logic [`CLKGEN_DATA_W-1:0]      DO,
  output logic                           DRDY
);

  logic                      ch_hit;   // address falls on a channel register
  logic                      st_hit;
  logic [2:0]                ch_idx;
  logic [`CLKGEN_DATA_W-1:0] rd_data;

  // ####################################################################
  // address decode
  // ####################################################################

  assign ch_idx = req.addr[2:0];
  assign ch_hit = (req.addr < `CLKGEN_ADDR_W'(`CLKGEN_NUM_CH));
  assign st_hit = (req.addr == `CLKGEN_ADDR_STATUS);

  // read mux, same bit layout as a write
  always_comb
  begin
    rd_data = '0;
    if (ch_hit)
    begin
      rd_data[`CLKGEN_DIVCFG_W-1:0] = ch_cfg[ch_idx].divcfg;
      rd_data[15:8]                 = ch_cfg[ch_idx].phase;
    end
    else if (st_hit)
    begin
      rd_data[0] = locked;
    end
  end

  // ####################################################################
  // configuration storage
  // ####################################################################

  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `CLKGEN_NUM_CH; i++)
      begin
        ch_cfg[i] <= '0;   // divide by 2 with no offset
      end
    end
    else if (req.en && req.we && ch_hit)
    begin
      ch_cfg[ch_idx] <= '{phase:  req.data[15:8],
                          divcfg: req.data[`CLKGEN_DIVCFG_W-1:0]};
    end
  end

  // response and restart one cycle after the request
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      DRDY    <= 1'b0;
      restart <= 1'b0;
      DO      <= '0;
    end
    else
    begin
      DRDY    <= req.en;
      restart <= req.en & req.we;   // realigns every channel
      DO      <= (req.en && !req.we) ? rd_data : '0;
    end
  end

  // response only ever follows a request
  drdy_after_en: assert property (
    @(posedge CLKIN1) disable iff (reset)
    DRDY |-> $past(req.en)
  ) else $error("DRDY without a preceding DEN");

endmodule

`default_nettype wire

// File: hdl/clkgen_lock_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_macros.svh"

module clkgen_lock_monitor (
  input  wire logic                      CLKIN1,
  input  wire logic                      reset,
  input  wire logic                      restart,
  input  wire logic [`CLKGEN_NUM_CH-1:0] div_out,
  output logic                           CLKOUT0,
  output logic                           CLKOUT1,
  output logic                           CLKOUT2,
  output logic                           CLKOUT3,
  output logic                           CLKOUT4,
  output logic                           CLKOUT5,
  output logic                           CLKOUT6,
  output logic                           CLKOUT0B,
  output logic                           CLKOUT1B,
  output logic                           CLKOUT2B,
  output logic                           CLKOUT3B,
  output logic                           LOCKED
);

  clkgen_pkg::lock_state_e   state;
  logic [`CLKGEN_LOCK_W-1:0] settle_cnt;
  logic [`CLKGEN_NUM_CH-1:0] clk_q;   // div_out, one cycle later

  // ####################################################################
  // settle FSM
  // ####################################################################

  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      state      <= clkgen_pkg::LOCK_SETTLE;
      settle_cnt <= `CLKGEN_LOCK_W'(`CLKGEN_LOCK_CYCLES);
    end
    else if (restart)
    begin
      state      <= clkgen_pkg::LOCK_SETTLE;   // settle again after a write
      settle_cnt <= `CLKGEN_LOCK_W'(`CLKGEN_LOCK_CYCLES);
    end
    else if (state == clkgen_pkg::LOCK_SETTLE)
    begin
      settle_cnt <= settle_cnt - 1'b1;
      if (settle_cnt == `CLKGEN_LOCK_W'(1))
        state <= clkgen_pkg::LOCK_DONE;   // last settle edge
    end
  end

  assign LOCKED = (state == clkgen_pkg::LOCK_DONE);

  // output stage
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
      clk_q <= '0;
    else
      clk_q <= div_out;
  end

  assign CLKOUT0  = LOCKED & clk_q[0];
  assign CLKOUT1  = LOCKED & clk_q[1];
  assign CLKOUT2  = LOCKED & clk_q[2];
  assign CLKOUT3  = LOCKED & clk_q[3];
  assign CLKOUT4  = LOCKED & clk_q[4];
  assign CLKOUT5  = LOCKED & clk_q[5];
  assign CLKOUT6  = LOCKED & clk_q[6];
  assign CLKOUT0B = LOCKED & ~clk_q[0];   // low, not high, while unlocked
  assign CLKOUT1B = LOCKED & ~clk_q[1];
  assign CLKOUT2B = LOCKED & ~clk_q[2];
  assign CLKOUT3B = LOCKED & ~clk_q[3];

  no_early_lock: assert property (
    @(posedge CLKIN1) disable iff (reset)
    LOCKED |-> (settle_cnt == '0)
  ) else $error("LOCKED high with settle count %0d", settle_cnt);

endmodule

`default_nettype wire

// File: hdl/clkgen_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_macros.svh"

module clkgen_top (
  input  wire logic                      CLKIN1,
  input  wire logic                      reset,
  input  wire logic                      DEN,
  input  wire logic                      DWE,
  input  wire logic [`CLKGEN_ADDR_W-1:0] DADDR,
  input  wire logic [`CLKGEN_DATA_W-1:0] DI,
  output logic [`CLKGEN_DATA_W-1:0]      DO,
  output logic                           DRDY,
  output logic                           CLKOUT0,
  output logic                           CLKOUT1,
  output logic                           CLKOUT2,
  output logic                           CLKOUT3,
  output logic                           CLKOUT4,
  output logic                           CLKOUT5,
  output logic                           CLKOUT6,
  output logic                           CLKOUT0B,
  output logic                           CLKOUT1B,
  output logic                           CLKOUT2B,
  output logic                           CLKOUT3B,
  output logic                           LOCKED
);

  clkgen_pkg::drp_req_t      drp_req;
  clkgen_pkg::div_cfg_t      ch_cfg [`CLKGEN_NUM_CH];
  logic                      restart;   // pulse after every write
  logic [`CLKGEN_NUM_CH-1:0] div_out;

  assign drp_req = clkgen_pkg::drp_req_t'{en: DEN, we: DWE, addr: DADDR, data: DI};

  // ####################################################################
  // register block
  // ####################################################################

  clkgen_cfg_regs u_regs (
    .CLKIN1  (CLKIN1),
    .reset   (reset),
    .req     (drp_req),
    .locked  (LOCKED),
    .ch_cfg  (ch_cfg),
    .restart (restart),
    .DO      (DO),
    .DRDY    (DRDY)
  );

  // one divider per output channel
  genvar i;
  generate
    for (i = 0; i < `CLKGEN_NUM_CH; i++)
    begin : gen_ch
      clock_divider u_div (
        .CLKIN1  (CLKIN1),
        .reset   (reset),
        .restart (restart),
        .cfg     (ch_cfg[i]),
        .div_out (div_out[i])
      );
    end
  endgenerate

  clkgen_lock_monitor u_lock (
    .CLKIN1   (CLKIN1),
    .reset    (reset),
    .restart  (restart),
    .div_out  (div_out),
    .CLKOUT0  (CLKOUT0),
    .CLKOUT1  (CLKOUT1),
    .CLKOUT2  (CLKOUT2),
    .CLKOUT3  (CLKOUT3),
    .CLKOUT4  (CLKOUT4),
    .CLKOUT5  (CLKOUT5),
    .CLKOUT6  (CLKOUT6),
    .CLKOUT0B (CLKOUT0B),
    .CLKOUT1B (CLKOUT1B),
    .CLKOUT2B (CLKOUT2B),
    .CLKOUT3B (CLKOUT3B),
    .LOCKED   (LOCKED)
  );

endmodule

`default_nettype wire

// File: dv/clkgen_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "clkgen_macros.svh"

module clkgen_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_CH       = `CLKGEN_NUM_CH;
  localparam int LOCK_CYCLES  = `CLKGEN_LOCK_CYCLES;
  localparam int WR_ROUNDS    = 24;
  localparam int BURSTS       = 3;
  localparam int BURST_LEN    = 4;
  localparam int RUN_CYCLES   = 64;
  localparam int ROUND_CYCLES = RUN_CYCLES + 32 + 48;   // rough upper bound per round
  localparam int TEST_CYCLES  = 40 + (WR_ROUNDS + BURSTS) * ROUND_CYCLES;

  logic        CLKIN1 = 1'b0;
  logic        reset  = 1'b1;
  logic        DEN    = 1'b0;
  logic        DWE    = 1'b0;
  logic [6:0]  DADDR  = '0;
  logic [15:0] DI     = '0;
  logic [15:0] DO;
  logic        DRDY;
  logic        CLKOUT0, CLKOUT1, CLKOUT2, CLKOUT3, CLKOUT4, CLKOUT5, CLKOUT6;
  logic        CLKOUT0B, CLKOUT1B, CLKOUT2B, CLKOUT3B;
  logic        LOCKED;

  // reference model state
  logic [2:0]  m_div   [NUM_CH];
  logic [7:0]  m_phase [NUM_CH];
  logic [7:0]  m_cnt;
  int          m_settle;
  logic        m_drdy;
  logic        m_restart;
  logic [15:0] m_do;
  logic [6:0]  m_clkq;    // model div_out, one cycle late

  wire       m_locked    = (m_settle == 0);
  wire [6:0] clkout_vec  = {CLKOUT6, CLKOUT5, CLKOUT4, CLKOUT3, CLKOUT2, CLKOUT1, CLKOUT0};
  wire [3:0] clkoutb_vec = {CLKOUT3B, CLKOUT2B, CLKOUT1B, CLKOUT0B};
  wire [6:0] exp_clkout  = m_locked ? m_clkq : 7'h00;
  wire [3:0] exp_clkoutb = m_locked ? ~m_clkq[3:0] : 4'h0;

  clkgen_top uut (
    .CLKIN1 (CLKIN1), .reset (reset), .DEN (DEN), .DWE (DWE), .DADDR (DADDR), .DI (DI),
    .DO (DO), .DRDY (DRDY),
    .CLKOUT0 (CLKOUT0), .CLKOUT1 (CLKOUT1), .CLKOUT2 (CLKOUT2), .CLKOUT3 (CLKOUT3),
    .CLKOUT4 (CLKOUT4), .CLKOUT5 (CLKOUT5), .CLKOUT6 (CLKOUT6),
    .CLKOUT0B (CLKOUT0B), .CLKOUT1B (CLKOUT1B), .CLKOUT2B (CLKOUT2B), .CLKOUT3B (CLKOUT3B),
    .LOCKED (LOCKED)
  );

  always #(CLK_PERIOD / 2) CLKIN1 = ~CLKIN1;

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("error: %s = %h, expected %h", name, got, exp);
    fail_run();
  endtask

  // channel register layout with phase in the high byte
  function automatic logic [15:0] reg_layout(input logic [2:0] div, input logic [7:0] phase);
    reg_layout = {phase, 5'b00000, div};
  endfunction

  function automatic logic [15:0] model_read(input logic [6:0] addr);
    if (addr < NUM_CH)
      model_read = reg_layout(m_div[addr[2:0]], m_phase[addr[2:0]]);
    else if (addr == `CLKGEN_ADDR_STATUS)
      model_read = {15'h0000, m_locked};
    else
      model_read = 16'h0000;   // unmapped
  endfunction

  // ####################################################################
  // reference model
  // ####################################################################

  always @(posedge CLKIN1 or posedge reset)
  begin
    logic [7:0] sum;
    if (reset)
    begin
      for (int i = 0; i < NUM_CH; i++)
      begin
        m_div[i]   <= '0;
        m_phase[i] <= '0;
      end
      m_cnt     <= '0;
      m_settle  <= LOCK_CYCLES;
      m_drdy    <= 1'b0;
      m_restart <= 1'b0;
      m_do      <= '0;
      m_clkq    <= '0;
    end
    else
    begin
      m_drdy    <= DEN;
      m_restart <= DEN && DWE;
      m_do      <= (DEN && !DWE) ? model_read(DADDR) : 16'h0000;
      if (DEN && DWE && (DADDR < NUM_CH))
      begin
        m_div[DADDR[2:0]]   <= DI[2:0];
        m_phase[DADDR[2:0]] <= DI[15:8];
      end
      m_cnt <= m_restart ? 8'h00 : m_cnt + 8'h01;
      if (m_restart)
        m_settle <= LOCK_CYCLES;   // settle starts over
      else if (m_settle != 0)
        m_settle <= m_settle - 1;
      for (int i = 0; i < NUM_CH; i++)
      begin
        sum = m_cnt + m_phase[i];
        m_clkq[i] <= sum[m_div[i]];
      end
    end
  end

  // ####################################################################
  // checks
  // ####################################################################

  drdy_matches: assert property (@(posedge CLKIN1) disable iff (reset) DRDY == m_drdy)
    else report_mismatch("DRDY", 16'($sampled(DRDY)), 16'($sampled(m_drdy)));

  do_matches: assert property (@(posedge CLKIN1) disable iff (reset) DO == m_do)
    else report_mismatch("DO", $sampled(DO), $sampled(m_do));

  locked_matches: assert property (@(posedge CLKIN1) disable iff (reset) LOCKED == m_locked)
    else report_mismatch("LOCKED", 16'($sampled(LOCKED)), 16'($sampled(m_locked)));

  clkout_matches: assert property (@(posedge CLKIN1) disable iff (reset)
    clkout_vec == exp_clkout)
    else report_mismatch("CLKOUT6..0", 16'($sampled(clkout_vec)), 16'($sampled(exp_clkout)));

  clkoutb_matches: assert property (@(posedge CLKIN1) disable iff (reset)
    clkoutb_vec == exp_clkoutb)
    else report_mismatch("CLKOUT3B..0B", 16'($sampled(clkoutb_vec)),
                         16'($sampled(exp_clkoutb)));

  // inverted outputs against the plain ones
  clkoutb_inverse: assert property (@(posedge CLKIN1) disable iff (reset)
    LOCKED |-> (clkoutb_vec == ~clkout_vec[3:0]))
    else report_mismatch("CLKOUT3B..0B", 16'($sampled(clkoutb_vec)),
                         16'(~$sampled(clkout_vec[3:0])));

  // ####################################################################
  // stimulus
  // ####################################################################

  task automatic wait_drdy();
    int n;
    n = 0;
    @(negedge CLKIN1);
    while (!DRDY && n < 4)
    begin
      @(negedge CLKIN1);
      n++;
    end
    if (!DRDY)
    begin
      $display("no DRDY within 4 cycles of a register request");
      fail_run();
    end
  endtask

  task automatic wait_locked();
    int n;
    n = 0;
    @(negedge CLKIN1);
    while (!LOCKED && n < 2 * LOCK_CYCLES)
    begin
      @(negedge CLKIN1);
      n++;
    end
    if (!LOCKED)
    begin
      $display("LOCKED did not rise within twice the settling time");
      fail_run();
    end
  endtask

  task automatic drp_access(input logic we, input logic [6:0] addr, input logic [15:0] data);
    @(posedge CLKIN1);
    DEN   <= 1'b1;
    DWE   <= we;
    DADDR <= addr;
    DI    <= data;
    @(posedge CLKIN1);
    DEN   <= 1'b0;
    DWE   <= 1'b0;
    wait_drdy();
  endtask

  // writes on consecutive cycles that each restart the lock count
  task automatic write_burst(input int len);
    for (int k = 0; k < len; k++)
    begin
      @(posedge CLKIN1);
      DEN   <= 1'b1;
      DWE   <= 1'b1;
      DADDR <= 7'($urandom_range(0, NUM_CH - 1));
      DI    <= 16'($urandom);
    end
    @(posedge CLKIN1);
    DEN <= 1'b0;
    DWE <= 1'b0;
    wait_drdy();
    wait_locked();
  endtask

  initial
  begin
    logic [6:0] addr;
    void'($urandom(32'h3aef));
    repeat (5) @(posedge CLKIN1);
    reset <= 1'b0;
    wait_locked();
    repeat (RUN_CYCLES) @(posedge CLKIN1);

    for (int r = 0; r < WR_ROUNDS; r++)
    begin
      addr = 7'($urandom_range(0, NUM_CH - 1));
      drp_access(1'b1, addr, 16'($urandom));   // spare bits random too
      drp_access(1'b0, addr, 16'h0000);
      drp_access(1'b0, `CLKGEN_ADDR_STATUS, 16'h0000);   // still settling
      wait_locked();
      drp_access(1'b0, `CLKGEN_ADDR_STATUS, 16'h0000);
      addr = (r % 2 == 0) ? 7'd7 : 7'($urandom_range(9, 127));
      drp_access(1'b0, addr, 16'h0000);
      repeat (RUN_CYCLES + $urandom_range(0, 31)) @(posedge CLKIN1);
    end

    for (int b = 0; b < BURSTS; b++)
    begin
      write_burst(BURST_LEN);
      repeat (RUN_CYCLES) @(posedge CLKIN1);
    end

    $display("Done: no errors");
    $finish;
  end

  // watchdog
  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("simulation ran past its time limit");
    fail_run();
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+common
common/clkgen_pkg.sv
clock_divider/clock_divider.sv
hdl/clkgen_cfg_regs.sv
hdl/clkgen_lock_monitor.sv
hdl/clkgen_top.sv
dv/clkgen_tb.sv

// File: Makefile
# Verilator build and run for the clock generator testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = clkgen_tb
FLIST    = flist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FLIST)) common/clkgen_macros.svh

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
